//--- logic/fp_scale_pkg.sv
/*
 * Scale unit shared definitions
 * Default word widths, configuration register map and control bit positions
 */

package fp_scale_pkg;

    // Word layout defaults for single precision
    localparam int DEF_EXP_WIDTH  = 8;   // Biased exponent bits
    localparam int DEF_FRAC_WIDTH = 23;  // Stored fraction bits, no hidden bit

    // Configuration bus
    localparam int CFG_DATA_WIDTH = 32;  // Write and read data width

    typedef logic [0:0]                cfg_addr_t;  // Two registers, one address bit
    typedef logic [CFG_DATA_WIDTH-1:0] cfg_data_t;  // Configuration data word

    // Register map
    localparam cfg_addr_t CFG_ADDR_CTRL = 1'b0;  // Sign flip and force-zero controls
    localparam cfg_addr_t CFG_ADDR_EXP  = 1'b1;  // Signed exponent offset, modulo width

    // Control register fields
    localparam int CTRL_FLIP_SIGN_BIT  = 0;  // Negative factor selected
    localparam int CTRL_FORCE_ZERO_BIT = 1;  // Factor is zero

endpackage

//--- logic/scale_config_regs.sv
/*
 * Scale factor register block
 * Holds the control and exponent offset registers and drives them to the datapath
 */

`timescale 1ns/1ps

module scale_config_regs #(
    parameter int EXP_WIDTH = 8
) (
    input  logic                      clk_i,
    input  logic                      rst_i,

    // Configuration bus
    input  logic                      cfg_we_i,
    input  fp_scale_pkg::cfg_addr_t   cfg_addr_i,
    input  fp_scale_pkg::cfg_data_t   cfg_wdata_i,
    output fp_scale_pkg::cfg_data_t   cfg_rdata_o,

    // Stored factor as plain levels
    output logic                      flip_sign_o,
    output logic                      force_zero_o,
    output logic [EXP_WIDTH-1:0]      exp_offset_o
);

    import fp_scale_pkg::*;

    typedef logic [EXP_WIDTH-1:0] exp_t;

    logic      flip_sign_q;   // Control bit 0
    logic      force_zero_q;  // Control bit 1
    exp_t      exp_offset_q;  // Offset added to normal exponents
    cfg_data_t rdata;

    // Reset gives a factor of +1
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            flip_sign_q  <= 1'b0;
            force_zero_q <= 1'b0;
            exp_offset_q <= '0;
        end else if (cfg_we_i) begin
            case (cfg_addr_i)
                CFG_ADDR_CTRL: begin
                    flip_sign_q  <= cfg_wdata_i[CTRL_FLIP_SIGN_BIT];   // Other bits dropped
                    force_zero_q <= cfg_wdata_i[CTRL_FORCE_ZERO_BIT];
                end
                CFG_ADDR_EXP: begin
                    exp_offset_q <= cfg_wdata_i[EXP_WIDTH-1:0];  // Upper bits ignored
                end
            endcase
        end
    end

    // The read mux zero-extends the addressed register to the bus width
    always_comb begin
        rdata = '0;
        case (cfg_addr_i)
            CFG_ADDR_CTRL: begin
                rdata[CTRL_FLIP_SIGN_BIT]  = flip_sign_q;
                rdata[CTRL_FORCE_ZERO_BIT] = force_zero_q;
            end
            CFG_ADDR_EXP: begin
                rdata[EXP_WIDTH-1:0] = exp_offset_q;
            end
        endcase
    end

    assign cfg_rdata_o  = rdata;
    assign flip_sign_o  = flip_sign_q;
    assign force_zero_o = force_zero_q;
    assign exp_offset_o = exp_offset_q;

endmodule

//--- logic/fp_pow2_scaler.sv
/*
 * Power of two scaler
 * Two stage pipeline that multiplies a float by a signed power of two or by zero
 */

`timescale 1ns/1ps

module fp_pow2_scaler #(
    parameter  int EXP_WIDTH  = 8,
    parameter  int FRAC_WIDTH = 23,
    localparam int FP_WIDTH   = 1 + EXP_WIDTH + FRAC_WIDTH
) (
    input  logic                  clk_i,
    input  logic                  rst_i,

    // Sample stream
    input  logic [FP_WIDTH-1:0]   fp_i,
    input  logic                  valid_i,

    // Factor from the register block
    input  logic                  flip_sign_i,
    input  logic                  force_zero_i,
    input  logic [EXP_WIDTH-1:0]  exp_offset_i,

    // Scaled stream two cycles later
    output logic [FP_WIDTH-1:0]   fp_o,
    output logic                  valid_o
);

    localparam int SIGN_IDX = EXP_WIDTH + FRAC_WIDTH;   // Sign sits on top
    localparam int EXP_LSB  = FRAC_WIDTH;
    localparam int EXP_MSB  = FRAC_WIDTH + EXP_WIDTH - 1;

    typedef logic [FP_WIDTH-1:0]   fp_word_t;
    typedef logic [EXP_WIDTH-1:0]  exp_t;
    typedef logic [FRAC_WIDTH-1:0] frac_t;

    localparam exp_t EXP_MAX = '1;  // Infinity and NaN exponent

    // Stage 0 holds the input word with the factor that was held when it arrived
    fp_word_t fp_s0;
    logic     valid_s0;
    logic     flip_s0;
    logic     zero_s0;
    exp_t     offset_s0;

    // Stage 1 holds the result word
    fp_word_t fp_s1;
    logic     valid_s1;

    // Split fields and the adjusted result
    logic     sign_in;
    exp_t     exp_in;
    frac_t    frac_in;
    logic     sign_res;
    exp_t     exp_res;
    frac_t    frac_res;
    fp_word_t fp_res;

    // Capturing the factor here lets later writes leave this sample alone
    always_ff @(posedge clk_i) begin
        fp_s0     <= fp_i;
        flip_s0   <= flip_sign_i;
        zero_s0   <= force_zero_i;
        offset_s0 <= exp_offset_i;
        fp_s1     <= fp_res;
    end

    always_comb begin
        sign_in = fp_s0[SIGN_IDX];
        exp_in  = fp_s0[EXP_MSB:EXP_LSB];
        frac_in = fp_s0[FRAC_WIDTH-1:0];

        sign_res = sign_in ^ flip_s0;  // Negative factor
        exp_res  = exp_in;
        frac_res = frac_in;

        // Only normal numbers move; wraps silently on overflow
        if ((exp_in != '0) && (exp_in != EXP_MAX)) begin
            exp_res = exp_in + offset_s0;
        end

        if (zero_s0) begin
            exp_res  = '0;  // Signed zero keeps the computed sign
            frac_res = '0;
        end

        fp_res = {sign_res, exp_res, frac_res};
    end

    // Valid bits of both stages
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_s0 <= 1'b0;
            valid_s1 <= 1'b0;
        end else begin
            valid_s0 <= valid_i;
            valid_s1 <= valid_s0;
        end
    end

    assign fp_o    = fp_s1;
    assign valid_o = valid_s1;

endmodule

//--- logic/fp_scale_top.sv
/*
 * Floating point scaling unit
 * Register block for the scale factor beside the two stage scaler it steers
 */

`timescale 1ns/1ps

module fp_scale_top #(
    parameter  int EXP_WIDTH  = fp_scale_pkg::DEF_EXP_WIDTH,
    parameter  int FRAC_WIDTH = fp_scale_pkg::DEF_FRAC_WIDTH,
    localparam int FP_WIDTH   = 1 + EXP_WIDTH + FRAC_WIDTH
) (
    input  logic                      clk_i,
    input  logic                      rst_i,

    // Configuration bus
    input  logic                      cfg_we_i,
    input  fp_scale_pkg::cfg_addr_t   cfg_addr_i,
    input  fp_scale_pkg::cfg_data_t   cfg_wdata_i,
    output fp_scale_pkg::cfg_data_t   cfg_rdata_o,

    // Sample stream, no back-pressure
    input  logic [FP_WIDTH-1:0]       fp_i,
    input  logic                      valid_i,
    output logic [FP_WIDTH-1:0]       fp_o,
    output logic                      valid_o
);

    logic                 flip_sign;   // Negative factor
    logic                 force_zero;  // Zero factor
    logic [EXP_WIDTH-1:0] exp_offset;  // Power of two, modulo exponent width

    scale_config_regs #(
        .EXP_WIDTH    (EXP_WIDTH)
    ) u_regs (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .cfg_we_i     (cfg_we_i),
        .cfg_addr_i   (cfg_addr_i),
        .cfg_wdata_i  (cfg_wdata_i),
        .cfg_rdata_o  (cfg_rdata_o),
        .flip_sign_o  (flip_sign),
        .force_zero_o (force_zero),
        .exp_offset_o (exp_offset)
    );

    fp_pow2_scaler #(
        .EXP_WIDTH    (EXP_WIDTH),
        .FRAC_WIDTH   (FRAC_WIDTH)
    ) u_scaler (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .fp_i         (fp_i),
        .valid_i      (valid_i),
        .flip_sign_i  (flip_sign),
        .force_zero_i (force_zero),
        .exp_offset_i (exp_offset),
        .fp_o         (fp_o),
        .valid_o      (valid_o)
    );

endmodule

//--- verification/fp_scale_asserts.sv
/*
 * Scaling unit assertions
 * Reset and valid timing of the pipeline, and the read bus width
 */

`timescale 1ns/1ps

module fp_scale_asserts #(
    parameter int EXP_WIDTH = 8
) (
    input logic                    clk_i,
    input logic                    rst_i,
    input logic                    valid_i,
    input logic                    valid_o,
    input fp_scale_pkg::cfg_data_t cfg_rdata_o
);

    import fp_scale_pkg::*;

    logic [1:0] run_cycles;  // Edges since reset released, stops at 2

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            run_cycles <= 2'd0;
        end else if (run_cycles != 2'd2) begin
            run_cycles <= run_cycles + 2'd1;
        end
    end

    valid_low_after_reset: assert property (@(posedge clk_i) rst_i |=> !valid_o)
        else $error("valid_o high in the cycle after reset");

    // Both pipeline stages must be clear of reset before the delay holds
    valid_delay_two: assert property (@(posedge clk_i)
        (run_cycles == 2'd2) |-> (valid_o == $past(valid_i, 2)))
        else $error("valid_o is not valid_i delayed by two cycles");

    rdata_upper_zero: assert property (@(posedge clk_i)
        cfg_rdata_o[CFG_DATA_WIDTH-1:EXP_WIDTH] == '0)
        else $error("cfg_rdata_o has bits set above the exponent width");

endmodule

bind fp_scale_top fp_scale_asserts #(
    .EXP_WIDTH   (EXP_WIDTH)
) u_asserts (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .valid_i     (valid_i),
    .valid_o     (valid_o),
    .cfg_rdata_o (cfg_rdata_o)
);

//--- verification/fp_scale_tb.sv
/*
 * Scaling unit testbench
 * Random stimulus from a fixed seed, checked against a model of the scaling rules
 */

`timescale 1ns/1ps

module fp_scale_tb;

    import fp_scale_pkg::*;

    localparam int EXP_W       = DEF_EXP_WIDTH;
    localparam int FRAC_W      = DEF_FRAC_WIDTH;
    localparam int FP_W        = 1 + EXP_W + FRAC_W;
    localparam int DRAIN_LIMIT = 16;  // Cycles allowed for the pipeline to empty

    typedef logic [FP_W-1:0]   word_t;
    typedef logic [EXP_W-1:0]  exp_t;
    typedef logic [FRAC_W-1:0] frac_t;

    logic      clk_i;
    logic      rst_i;
    logic      cfg_we_i;
    cfg_addr_t cfg_addr_i;
    cfg_data_t cfg_wdata_i;
    cfg_data_t cfg_rdata_o;
    word_t     fp_i;
    logic      valid_i;
    word_t     fp_o;
    logic      valid_o;

    // Factor registers as the model sees them
    logic m_flip;
    logic m_zero;
    exp_t m_offset;

    word_t want_q[$];  // Expected words in acceptance order
    int    due_q[$];   // Cycle on which each word must show up

    int cycle_count = 0;
    int checks      = 0;
    int errors      = 0;
    int out_checks  = 0;
    int out_errors  = 0;
    int accepted    = 0;
    int pulses      = 0;
    int test_num    = 0;
    bit timed_out   = 1'b0;

    fp_scale_top dut_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o),
        .fp_i        (fp_i),
        .valid_i     (valid_i),
        .fp_o        (fp_o),
        .valid_o     (valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;  // Counts rising edges
    end

    // Sign flip, offset on normal exponents only, then force-zero
    function automatic word_t scale_model(input word_t w, input logic flip, input logic zero,
                                          input exp_t offset);
        logic  s;
        exp_t  e;
        frac_t f;
        s = w[FP_W-1] ^ flip;
        e = w[FP_W-2 -: EXP_W];
        f = w[FRAC_W-1:0];
        if (e != '0 && e != '1) begin
            e = e + offset;  // Wraps modulo the exponent width
        end
        if (zero) begin
            e = '0;
            f = '0;
        end
        return {s, e, f};
    endfunction

    function automatic cfg_data_t register_image(input cfg_addr_t addr);
        cfg_data_t v;
        v = '0;
        if (addr == CFG_ADDR_CTRL) begin
            v[CTRL_FLIP_SIGN_BIT]  = m_flip;
            v[CTRL_FORCE_ZERO_BIT] = m_zero;
        end else begin
            v[EXP_W-1:0] = m_offset;
        end
        return v;
    endfunction

    function automatic word_t random_normal();
        word_t w;
        w = $urandom();
        if (w[FP_W-2 -: EXP_W] == '0 || w[FP_W-2 -: EXP_W] == '1) begin
            w[FP_W-2 -: EXP_W] = exp_t'(1);
        end
        return w;
    endfunction

    function automatic word_t random_special(input int kind);
        word_t w;
        w = $urandom();
        case (kind % 4)
            0: begin
                w[FP_W-2:0] = '0;  // Signed zero
            end
            1: begin
                w[FP_W-2 -: EXP_W] = '0;  // Subnormal
                w[0] = 1'b1;
            end
            2: begin
                w[FP_W-2 -: EXP_W] = '1;  // Infinity
                w[FRAC_W-1:0] = '0;
            end
            default: begin
                w[FP_W-2 -: EXP_W] = '1;  // NaN
                w[FRAC_W-1] = 1'b1;
            end
        endcase
        return w;
    endfunction

    function automatic int total_errors();
        return errors + out_errors;
    endfunction

    // One clock of stimulus; a sample sees the factor held before this cycle's write
    task automatic drive_cycle(input logic smp, input word_t word, input logic wr,
                               input cfg_addr_t addr, input cfg_data_t data);
        @(posedge clk_i);
        #1;
        valid_i     = smp;
        fp_i        = word;
        cfg_we_i    = wr;
        cfg_addr_i  = addr;
        cfg_wdata_i = data;
        if (smp) begin
            want_q.push_back(scale_model(word, m_flip, m_zero, m_offset));
            due_q.push_back(cycle_count + 2);  // Accepted on the next edge and out one edge later
            accepted++;
        end
        if (wr && addr == CFG_ADDR_CTRL) begin
            m_flip = data[CTRL_FLIP_SIGN_BIT];
            m_zero = data[CTRL_FORCE_ZERO_BIT];
        end else if (wr) begin
            m_offset = data[EXP_W-1:0];
        end
    endtask

    task automatic set_factor(input logic flip, input logic zero, input exp_t offset);
        cfg_data_t d;
        d = $urandom();  // Unused upper bits must not be stored
        d[CTRL_FLIP_SIGN_BIT]  = flip;
        d[CTRL_FORCE_ZERO_BIT] = zero;
        drive_cycle(1'b0, '0, 1'b1, CFG_ADDR_CTRL, d);
        d = $urandom();
        d[EXP_W-1:0] = offset;
        drive_cycle(1'b0, '0, 1'b1, CFG_ADDR_EXP, d);
    endtask

    task automatic check_read(input cfg_addr_t addr);
        cfg_data_t want;
        drive_cycle(1'b0, '0, 1'b0, addr, '0);
        want = register_image(addr);
        @(negedge clk_i);
        checks++;
        if (cfg_rdata_o !== want) begin
            errors++;
            $display("error at %0t: register %0d reads %h, expected %h",
                     $time, addr, cfg_rdata_o, want);
        end
    endtask

    task automatic drain_pipeline();
        int waited;
        waited = 0;
        drive_cycle(1'b0, '0, 1'b0, CFG_ADDR_CTRL, '0);
        while (want_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        if (want_q.size() != 0) begin
            timed_out = 1'b1;
            errors++;
            $display("timeout: %0d accepted samples never came out on valid_o", want_q.size());
            want_q.delete();
            due_q.delete();
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        int n;
        test_num++;
        n = total_errors() - err_before;
        if (n == 0) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, name, n);
        end
    endtask

    // The checker samples on the falling edge where outputs are settled
    always @(negedge clk_i) begin
        word_t want;
        int    due;
        if (!rst_i && valid_o === 1'b1) begin
            pulses++;
            if (want_q.size() == 0) begin
                out_errors++;
                $display("error at %0t: valid_o pulse with no accepted sample", $time);
            end else begin
                want = want_q.pop_front();
                due  = due_q.pop_front();
                out_checks++;
                if (fp_o !== want) begin
                    out_errors++;
                    $display("error at %0t: fp_o %h, expected %h", $time, fp_o, want);
                end
                if (cycle_count != due) begin
                    out_errors++;
                    $display("error at %0t: output on cycle %0d, expected cycle %0d",
                             $time, cycle_count, due);
                end
            end
        end
    end

    task automatic test_after_reset();
        int err0;
        int pulses0;
        err0 = total_errors();
        check_read(CFG_ADDR_CTRL);
        check_read(CFG_ADDR_EXP);
        pulses0 = pulses;
        repeat (6) drive_cycle(1'b0, '0, 1'b0, CFG_ADDR_CTRL, '0);
        checks++;
        if (pulses != pulses0) begin
            errors++;
            $display("error at %0t: %0d valid_o pulses with no input", $time, pulses - pulses0);
        end
        repeat (16) drive_cycle(1'b1, $urandom(), 1'b0, CFG_ADDR_CTRL, '0);
        drain_pipeline();
        report_test("reset state and pass-through", err0);
    endtask

    task automatic test_readback();
        int          err0;
        logic [31:0] r;
        err0 = total_errors();
        for (int i = 0; i < 20; i++) begin
            r = $urandom();
            drive_cycle(1'b0, '0, 1'b1, cfg_addr_t'(r[0]), $urandom());
            check_read(cfg_addr_t'(r[0]));
            check_read(cfg_addr_t'(~r[0]));
        end
        report_test("register readback", err0);
    endtask

    task automatic test_offsets();
        int          err0;
        logic [31:0] r;
        err0 = total_errors();
        for (int b = 0; b < 8; b++) begin
            r = $urandom();
            set_factor(r[8], 1'b0, r[EXP_W-1:0]);  // Earlier burst still in flight
            for (int i = 0; i < 16; i++) begin
                drive_cycle(1'b1, random_normal(), 1'b0, CFG_ADDR_CTRL, '0);
            end
        end
        drain_pipeline();
        report_test("exponent offset and sign flip", err0);
    endtask

    task automatic test_specials();
        int          err0;
        logic [31:0] r;
        err0 = total_errors();
        for (int b = 0; b < 2; b++) begin
            r = $urandom();
            set_factor(b[0], 1'b0, r[EXP_W-1:0] | exp_t'(1));  // One burst of each sign
            for (int i = 0; i < 20; i++) begin
                drive_cycle(1'b1, random_special(i), 1'b0, CFG_ADDR_CTRL, '0);
            end
        end
        drain_pipeline();
        report_test("special exponents", err0);
    endtask

    task automatic test_force_zero();
        int          err0;
        logic [31:0] r;
        err0 = total_errors();
        for (int b = 0; b < 2; b++) begin
            r = $urandom();
            set_factor(b[0], 1'b1, r[EXP_W-1:0]);
            for (int i = 0; i < 16; i++) begin
                drive_cycle(1'b1, $urandom(), 1'b0, CFG_ADDR_CTRL, '0);
            end
        end
        drain_pipeline();
        report_test("force-zero", err0);
    endtask

    task automatic test_stream();
        int          err0;
        int          acc0;
        int          pulses0;
        logic [31:0] r;
        err0    = total_errors();
        acc0    = accepted;
        pulses0 = pulses;
        for (int i = 0; i < 200; i++) begin
            r = $urandom();
            drive_cycle(r[2:0] != 3'd0, $urandom(), r[4:3] == 2'd0, cfg_addr_t'(r[5]),
                        $urandom());
        end
        drain_pipeline();
        checks++;
        if ((accepted - acc0) != (pulses - pulses0)) begin
            errors++;
            $display("error at %0t: %0d samples accepted but %0d valid_o pulses",
                     $time, accepted - acc0, pulses - pulses0);
        end
        report_test("configuration change in stream", err0);
    endtask

    initial begin
        void'($urandom(7));
        rst_i       = 1'b1;
        cfg_we_i    = 1'b0;
        cfg_addr_i  = CFG_ADDR_CTRL;
        cfg_wdata_i = '0;
        fp_i        = '0;
        valid_i     = 1'b0;
        m_flip      = 1'b0;  // Reset factor is +1
        m_zero      = 1'b0;
        m_offset    = '0;
        repeat (2) @(posedge clk_i);
        #1 rst_i = 1'b0;

        if (!timed_out) test_after_reset();
        if (!timed_out) test_readback();
        if (!timed_out) test_offsets();
        if (!timed_out) test_specials();
        if (!timed_out) test_force_zero();
        if (!timed_out) test_stream();

        $display("summary: %0d tests, %0d checks, %0d samples, %0d errors",
                 test_num, checks + out_checks, accepted, total_errors());
        if (total_errors() == 0 && !timed_out) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- compile.f
logic/fp_scale_pkg.sv
logic/scale_config_regs.sv
logic/fp_pow2_scaler.sv
logic/fp_scale_top.sv
verification/fp_scale_asserts.sv
verification/fp_scale_tb.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
TOP        := fp_scale_tb
FILELIST   := compile.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := Checks failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
